// File: sim.f
+incdir+common
common/cpu_pkg.sv
common/spi_pkg.sv
common/cpu_ifs.sv
core/inst_decoder.sv
core/exec_core.sv
spi_ram/spi_ram_ctrl.sv
verilog/cpu_top.sv
test/spi_ram_model.sv
test/cpu_chk.sv
test/tb_cpu.sv

// File: Makefile
SRCS := $(shell grep -v '^+' sim.f) common/cpu_consts.svh

.PHONY: run clean

obj_dir/Vtb_cpu: sim.f $(SRCS)
	verilator --binary --timing -j 0 -f sim.f --top-module tb_cpu -o Vtb_cpu

run: obj_dir/Vtb_cpu
	@out="$$(./obj_dir/Vtb_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^ALL CHECKS PASSED$$'

clean:
	rm -rf obj_dir

// File: test/cpu_patterns.txt
# m addr n word...  preload n big-endian words starting at addr
# s data_out halt trap n  take n steps, each followed by these outputs; r applies reset
m 0000 8 105A 50F0 600F 7033 30FF 400C A000 A100
m 0010 8 2880 1890 3892 A000 1880 A000 1000 9100
m 0020 8 A100 9000 A100 1078 A000 403C 9100 80F8
m 0030 8 C000 10AB A000 18A0 2800 A100 D000 0000
m 0040 3 10C5 A000 B000
m 0090 2 1234 0101
m 00A0 1 803E
s 00 0 0 6
s 5F 0 0 1
s 01 0 0 4
s 35 0 0 2
s 5F 0 0 5
s 00 0 0 2
s 78 0 0 4
s 3C 0 0 4
s 3C 0 1 1
s 3C 0 0 2
s AB 0 0 3
s 80 0 0 1
s 80 0 1 1
s 80 0 0 1
s 80 0 1 1
s 80 0 0 1
r
s 00 0 0 2
s C5 0 0 1
s C5 1 0 3

// File: test/tb_cpu.sv
// processor testbench: loads the pattern file, steps the processor and checks its outputs
`timescale 1ns/10ps
`include "cpu_consts.svh"

module tb_clk_gen (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    forever begin
      @(posedge rst_req); // reset again on request
      rst_n = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
    end
  end

endmodule

module tb_cpu;

  logic clk, rst_n, rst_req, step;
  logic busy, halt, trap;
  logic spi_clk, spi_select, spi_mosi, spi_miso;
  logic [`CPU_BYTE_W-1:0] data_out;

  int   errors;
  int   steps_total;
  int   resets_total;
  logic parsed;

  logic [`CPU_BYTE_W-1:0] exp_data_q[$];
  logic                   exp_halt_q[$];
  logic                   exp_trap_q[$];
  logic                   is_reset_q[$];

  tb_clk_gen u_clk_gen (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

  cpu_top u_cpu_top (
    .clk(clk), .rst_n(rst_n), .step(step), .busy(busy), .halt(halt), .trap(trap),
    .data_out(data_out), .spi_clk(spi_clk), .spi_select(spi_select),
    .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  spi_ram_model u_ram (
    .spi_clk(spi_clk), .spi_select(spi_select), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  // ----------------------------------------
  // pattern file
  // ----------------------------------------
  task automatic load_patterns();
    int fd, c, n, cnt;
    logic [15:0] addr, word;
    logic [7:0]  d;
    logic        h, t;
    fd = $fopen("test/cpu_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open test/cpu_patterns.txt");
      errors++;
      return;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        while (c != -1 && c != 10) c = $fgetc(fd); // rest of comment line
      end else if (c == "m") begin
        cnt = $fscanf(fd, " %h %d", addr, n);
        for (int i = 0; i < n; i++) begin
          cnt = $fscanf(fd, " %h", word);
          u_ram.mem_bytes[addr]         = word[15:8];
          u_ram.mem_bytes[addr + 16'd1] = word[7:0];
          addr = addr + 16'd2;
        end
      end else if (c == "s") begin
        cnt = $fscanf(fd, " %h %h %h %d", d, h, t, n);
        repeat (n) begin
          exp_data_q.push_back(d);
          exp_halt_q.push_back(h);
          exp_trap_q.push_back(t);
          is_reset_q.push_back(1'b0);
          steps_total++;
        end
      end else if (c == "r") begin
        exp_data_q.push_back('0);
        exp_halt_q.push_back(1'b0);
        exp_trap_q.push_back(1'b0);
        is_reset_q.push_back(1'b1);
        resets_total++;
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    if (steps_total == 0) begin
      $display("pattern file holds no steps");
      errors++;
    end
  endtask

  // ----------------------------------------
  // stepping and checks
  // ----------------------------------------
  task automatic run_step();
    logic seen;
    step = 1'b1;
    @(negedge clk);
    step = 1'b0;
    seen = busy;
    while (!((seen && !busy) || halt || trap)) begin
      @(negedge clk);
      if (busy) seen = 1'b1;
    end
  endtask

  task automatic check_outputs(input logic [7:0] d, input logic h, input logic t);
    assert (data_out == d) else begin
      $display("MISMATCH data_out expected %h actual %h", d, data_out);
      errors++;
    end
    assert (halt == h) else begin
      $display("MISMATCH halt expected %h actual %h", h, halt);
      errors++;
    end
    assert (trap == t) else begin
      $display("MISMATCH trap expected %h actual %h", t, trap);
      errors++;
    end
    assert (busy == 1'b0) else begin
      $display("MISMATCH busy expected %h actual %h", 1'b0, busy);
      errors++;
    end
    // serial bus is idle whenever the core is not busy
    assert (spi_select == 1'b1) else begin
      $display("MISMATCH spi_select expected %h actual %h", 1'b1, spi_select);
      errors++;
    end
    assert (spi_clk == 1'b0) else begin
      $display("MISMATCH spi_clk expected %h actual %h", 1'b0, spi_clk);
      errors++;
    end
    assert (spi_mosi == 1'b0) else begin
      $display("MISMATCH spi_mosi expected %h actual %h", 1'b0, spi_mosi);
      errors++;
    end
  endtask

  initial begin
    step         = 1'b0;
    rst_req      = 1'b0;
    errors       = 0;
    steps_total  = 0;
    resets_total = 0;
    parsed       = 1'b0;
    @(negedge clk); // after the model's own fill
    load_patterns();
    parsed = 1'b1;
    @(posedge rst_n);
    @(negedge clk);
    check_outputs('0, 1'b0, 1'b0);
    for (int i = 0; i < is_reset_q.size(); i++) begin
      if (is_reset_q[i]) begin
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
      end else begin
        run_step();
      end
      check_outputs(exp_data_q[i], exp_halt_q[i], exp_trap_q[i]);
    end
    $display("check errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog allows three transfers of at most 100 cycles per step
  initial begin
    int limit;
    wait (parsed);
    limit = steps_total * 3 * 100 + (resets_total + 1) * 10;
    repeat (limit) @(posedge clk);
    $display("run timed out after %0d cycles before all steps finished", limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: test/cpu_chk.sv
// protocol checker for the processor top level: control outputs and SPI pins
`timescale 1ns/10ps

module cpu_chk (
  input logic clk,
  input logic rst_n,
  input logic busy,
  input logic halt,
  input logic trap,
  input logic spi_clk,
  input logic spi_select
);

  a_one_status: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({busy, halt, trap}))
    else $error("more than one of busy, halt and trap is high");

  a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
    else $error("halt dropped without reset");

  a_sclk_select: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(spi_clk) |-> !spi_select)
    else $error("spi_clk toggled while spi_select was high");

  a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
    else $error("busy high right after reset release");

endmodule

bind cpu_top cpu_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .busy       (busy),
  .halt       (halt),
  .trap       (trap),
  .spi_clk    (spi_clk),
  .spi_select (spi_select)
);

// File: test/spi_ram_model.sv
// serial RAM model: answers SPI mode 0 read and write commands on a 64 KB byte array
`timescale 1ns/10ps
`include "cpu_consts.svh"

module spi_ram_model (
  input  logic spi_clk,
  input  logic spi_select,
  input  logic spi_mosi,
  output logic spi_miso
);

  logic [7:0]  mem_bytes [0:65535];
  logic [7:0]  cmd;
  logic [15:0] addr;
  logic [15:0] addr_lo;
  logic [15:0] rd_word;
  logic [15:0] wr_word;
  int          bit_cnt;

  initial begin
    logic [15:0] a;
    a = '0;
    for (int i = 0; i < 65536; i++) begin
      mem_bytes[i] = a[15:8] ^ a[7:0] ^ 8'ha5; // fill depends on every address bit
      a = a + 16'd1;
    end
    spi_miso = 1'b0;
    bit_cnt  = 0;
  end

  always @(negedge spi_select) bit_cnt = 0;

  // ----------------------------------------
  // mosi sampled on rising spi_clk
  // ----------------------------------------
  always @(posedge spi_clk) begin
    if (!spi_select) begin
      if (bit_cnt < 8) begin
        cmd = {cmd[6:0], spi_mosi};
      end else if (bit_cnt < 24) begin
        addr = {addr[14:0], spi_mosi};
      end else begin
        wr_word = {wr_word[14:0], spi_mosi};
      end
      bit_cnt = bit_cnt + 1;
      addr_lo = addr + 16'd1;
      if (bit_cnt == 24 && cmd == `SPI_CMD_READ) begin
        rd_word = {mem_bytes[addr], mem_bytes[addr_lo]};
      end
      if (bit_cnt == 40 && cmd == `SPI_CMD_WRITE) begin
        mem_bytes[addr]    = wr_word[15:8]; // big-endian
        mem_bytes[addr_lo] = wr_word[7:0];
      end
    end
  end

  // read data goes out on falling spi_clk
  always @(negedge spi_clk) begin
    if (!spi_select && bit_cnt >= 24 && bit_cnt < 40) begin
      spi_miso = rd_word[39 - bit_cnt];
    end
  end

endmodule

// File: verilog/cpu_top.sv
// processor top level: decoder, execution core and SPI RAM master
`timescale 1ns/10ps

module cpu_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       step,
  output logic       busy,
  output logic       halt,
  output logic       trap,
  output logic [7:0] data_out,
  output logic       spi_clk,
  output logic       spi_select,
  output logic       spi_mosi,
  input  logic       spi_miso
);

  mem_if mem_bus ();
  dec_if dec_bus ();

  inst_decoder u_decoder (
    .io (dec_bus.dec)
  );

  exec_core u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .step     (step),
    .dec      (dec_bus.core),
    .mem      (mem_bus.core),
    .busy     (busy),
    .halt     (halt),
    .trap     (trap),
    .data_out (data_out)
  );

  spi_ram_ctrl u_spi (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem        (mem_bus.ram),
    .spi_clk    (spi_clk),
    .spi_select (spi_select),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso)
  );

endmodule

// File: spi_ram/spi_ram_ctrl.sv
// SPI master for the serial RAM, one 16-bit read or write per request in mode 0
`timescale 1ns/10ps
`include "cpu_consts.svh"

module spi_ram_ctrl (
  input  logic clk,
  input  logic rst_n,
  mem_if.ram   mem,
  output logic spi_clk,
  output logic spi_select,
  output logic spi_mosi,
  input  logic spi_miso
);
  import spi_pkg::*;

  localparam int unsigned XFER_BITS = `CPU_BYTE_W + `SPI_ADDR_W + `CPU_WORD_W;
  localparam int unsigned CNT_W     = $clog2(XFER_BITS);
  localparam int unsigned HALF_DIV  = `SPI_CLK_DIV / 2;

  spi_state_t           state;
  logic [XFER_BITS-1:0] shreg;
  logic [CNT_W-1:0]     bit_cnt;
  logic [3:0]           div_cnt;
  logic                 div_tick;
  logic                 miso_q;   // sampled on rising spi_clk
  logic                 start;
  spi_cmd_t             cmd;

  assign start    = mem.start_read || mem.start_write;
  assign cmd      = mem.start_write ? `SPI_CMD_WRITE : `SPI_CMD_READ;
  assign div_tick = (div_cnt == 4'(HALF_DIV - 1));

  assign mem.busy = (state != spi_idle);
  assign spi_mosi = (state == spi_shift) && shreg[XFER_BITS-1];

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= spi_idle;
      spi_clk    <= 1'b0;
      spi_select <= 1'b1;
      bit_cnt    <= '0;
      div_cnt    <= '0;
    end else begin
      case (state)
        spi_idle: begin
          if (start) begin
            state      <= spi_shift;
            spi_select <= 1'b0;
            bit_cnt    <= '0;
            div_cnt    <= '0;
          end
        end
        spi_shift: begin
          if (div_tick) begin
            div_cnt <= '0;
            spi_clk <= !spi_clk;
            if (spi_clk) begin // falling edge ends a bit
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == CNT_W'(XFER_BITS - 1)) state <= spi_finish;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          spi_select <= 1'b1;
          state      <= spi_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // shift data path
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (state == spi_idle && start) begin
      shreg <= {cmd, mem.addr, mem.start_write ? mem.wdata : `CPU_WORD_W'(0)};
    end else if (state == spi_shift && div_tick) begin
      if (!spi_clk) begin
        miso_q <= spi_miso;
      end else begin
        shreg <= {shreg[XFER_BITS-2:0], miso_q};
      end
    end
    if (state == spi_finish) begin
      mem.rdata <= shreg[`CPU_WORD_W-1:0]; // last 16 bits in are the read word
    end
  end

endmodule

// File: core/exec_core.sv
// execution core: fetch/execute state machine with pc, accumulator, flags and output port
`timescale 1ns/10ps
`include "cpu_consts.svh"

module exec_core (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           step,
  dec_if.core            dec,
  mem_if.core            mem,
  output logic           busy,
  output logic           halt,
  output logic           trap,
  output cpu_pkg::byte_t data_out
);
  import cpu_pkg::*;

  core_state_t state;
  word_t       pc;
  word_t       acc;
  logic        zero;
  logic        skip;   // next instruction only advances pc

  word_t pc_next;
  word_t rhs;
  word_t alu_res;
  logic  alu_op;

  function automatic logic is_alu(opcode_t op);
    return op inside {op_load, op_add, op_sub, op_and, op_or, op_xor};
  endfunction

  function automatic word_t alu(opcode_t op, word_t a, word_t b);
    word_t r;
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      default: r = b; // load
    endcase
    return r;
  endfunction

  assign pc_next = pc + word_t'(`INST_BYTES);
  assign rhs     = (state == st_mem_wait) ? mem.rdata : dec.operand;
  assign alu_res = alu(dec.opcode, acc, rhs);
  assign alu_op  = is_alu(dec.opcode);

  assign busy = !(state inside {st_idle, st_halted, st_trapped});
  assign halt = (state == st_halted);
  assign trap = (state == st_trapped);

  // ----------------------------------------
  // memory requests
  // ----------------------------------------
  assign mem.addr  = (state inside {st_exec, st_mem_wait}) ? dec.operand : pc;
  assign mem.wdata = acc;

  assign mem.start_read = (state == st_fetch_req)
    || (state == st_exec && !skip && alu_op && dec.src_ram);
  assign mem.start_write = (state == st_exec) && !skip
    && (dec.opcode == op_store) && dec.src_ram;

  always_ff @(posedge clk) begin
    if (state == st_fetch_wait && !mem.busy) begin
      dec.inst <= mem.rdata;
    end
  end

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      pc       <= '0;
      acc      <= '0;
      zero     <= 1'b0;
      skip     <= 1'b0;
      data_out <= '0;
    end else begin
      case (state)
        st_idle:       if (step) state <= st_fetch_req;
        st_trapped:    if (step) state <= st_untrap;
        st_untrap:     state <= st_idle;
        st_fetch_req:  state <= st_fetch_wait;
        st_fetch_wait: if (!mem.busy) state <= st_exec;
        st_exec: begin
          skip <= 1'b0;
          if (skip) begin
            pc    <= pc_next;
            state <= st_idle;
          end else begin
            case (dec.opcode)
              op_load, op_add, op_sub, op_and, op_or, op_xor: begin
                if (dec.src_ram) begin
                  state <= st_mem_wait;
                end else begin
                  acc   <= alu_res;
                  zero  <= (alu_res == '0);
                  pc    <= pc_next;
                  state <= st_idle;
                end
              end
              op_store: state <= dec.src_ram ? st_mem_wait : st_trapped;
              op_branch: begin
                pc    <= pc_next + dec.operand;
                state <= st_idle;
              end
              op_if: begin
                skip  <= dec.sel ? zero : !zero; // set when the condition fails
                pc    <= pc_next;
                state <= st_idle;
              end
              op_out: begin
                data_out <= dec.sel ? acc[`CPU_WORD_W-1:`CPU_BYTE_W] : acc[`CPU_BYTE_W-1:0];
                pc       <= pc_next;
                state    <= st_idle;
              end
              op_halt: begin
                pc    <= pc_next;
                state <= st_halted;
              end
              op_trap: begin
                pc    <= pc_next;
                state <= st_trapped;
              end
              op_nop: begin
                pc    <= pc_next;
                state <= st_idle;
              end
              default: state <= st_trapped; // illegal opcode keeps pc
            endcase
          end
        end
        st_mem_wait: begin
          if (!mem.busy) begin
            if (dec.opcode != op_store) begin
              acc  <= alu_res;
              zero <= (alu_res == '0);
            end
            pc    <= pc_next;
            state <= st_idle;
          end
        end
        default: state <= st_halted; // st_halted holds until reset
      endcase
    end
  end

endmodule

// File: core/inst_decoder.sv
// instruction decoder: splits the fetched word into opcode, source, select and operand
`timescale 1ns/10ps
`include "cpu_consts.svh"

module inst_decoder (
  dec_if.dec io
);
  import cpu_pkg::*;

  logic [`OPC_MSB-`OPC_LSB:0] opc_raw;
  logic [`OPND_W-1:0]         opnd_raw;

  assign opc_raw  = io.inst[`OPC_MSB:`OPC_LSB];
  assign opnd_raw = io.inst[`OPND_W-1:0];

  // ----------------------------------------
  // opcode, 13..15 fold into one illegal code
  // ----------------------------------------
  always_comb begin
    if (opc_raw > op_trap) begin
      io.opcode = op_illegal;
    end else begin
      io.opcode = opcode_t'(opc_raw);
    end
  end

  assign io.src_ram = io.inst[`SRC_RAM_BIT];
  assign io.sel     = io.inst[`SEL_BIT];

  // ----------------------------------------
  // operand extension
  // ----------------------------------------
  always_comb begin
    if (io.opcode == op_branch) begin
      io.operand = {{(`CPU_WORD_W-`OPND_W){opnd_raw[`OPND_W-1]}}, opnd_raw}; // signed offset
    end else begin
      io.operand = {{(`CPU_WORD_W-`OPND_W){1'b0}}, opnd_raw};
    end
  end

endmodule

// File: common/cpu_ifs.sv
// memory request and instruction decode interfaces between core, decoder and SPI master
`timescale 1ns/10ps
`include "cpu_consts.svh"

interface mem_if;
  import cpu_pkg::*;

  word_t addr;
  word_t wdata;
  logic  start_read;  // one-cycle strobes, only while busy is low
  logic  start_write;
  word_t rdata;       // valid from busy falling until next start
  logic  busy;

  modport core (output addr, wdata, start_read, start_write, input rdata, busy);
  modport ram (input addr, wdata, start_read, start_write, output rdata, busy);
endinterface

interface dec_if;
  import cpu_pkg::*;

  word_t   inst;
  opcode_t opcode;
  logic    src_ram;
  logic    sel;      // if condition / out half
  word_t   operand;  // already extended

  modport core (output inst, input opcode, src_ram, sel, operand);
  modport dec (input inst, output opcode, src_ram, sel, operand);
endinterface

// File: common/spi_pkg.sv
// serial RAM types: command byte and SPI engine states
`include "cpu_consts.svh"

package spi_pkg;

  typedef logic [`CPU_BYTE_W-1:0] spi_cmd_t;

  typedef enum logic [1:0] {
    spi_idle,
    spi_shift,  // command, address and data bits on the wire
    spi_finish
  } spi_state_t;

endpackage

// File: common/cpu_pkg.sv
// processor types: data words, bytes, opcodes and core states
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_BYTE_W-1:0] byte_t;

  typedef enum logic [3:0] {
    op_nop     = 4'd0,
    op_load    = 4'd1,
    op_store   = 4'd2,
    op_add     = 4'd3,
    op_sub     = 4'd4,
    op_and     = 4'd5,
    op_or      = 4'd6,
    op_xor     = 4'd7,
    op_branch  = 4'd8,
    op_if      = 4'd9,
    op_out     = 4'd10,
    op_halt    = 4'd11,
    op_trap    = 4'd12,
    op_illegal = 4'd13 // stands for all of 13..15
  } opcode_t;

  typedef enum logic [2:0] {
    st_idle, st_halted, st_trapped, st_untrap,
    st_fetch_req, st_fetch_wait, st_exec, st_mem_wait
  } core_state_t;

endpackage

// File: common/cpu_consts.svh
// processor constants: widths, instruction fields, serial RAM commands and clock divide
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path
`define CPU_WORD_W 16
`define CPU_BYTE_W 8
`define INST_BYTES 2

// instruction fields
`define OPC_MSB 15
`define OPC_LSB 12
`define SRC_RAM_BIT 11
`define SEL_BIT 8
`define OPND_W 8

// serial RAM
`define SPI_CMD_READ 8'h03
`define SPI_CMD_WRITE 8'h02
`define SPI_ADDR_W 16
`define SPI_CLK_DIV 2 // spi_clk period in system clocks

`endif
